//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_rd_subsys
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILELIST  ?= tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -j 0 --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- axi_rd_arbiter.sv
`timescale 1ns/10ps

module axi_rd_arbiter (
  input  logic                                              clk,
  input  logic                                              i_arst_n,

  // manager side
  input  logic [axi_rd_pkg::NUM_M-1:0]                      i_s_arvalid,
  input  logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ID_W-1:0] i_s_arid,
  input  logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ADDR_W-1:0] i_s_araddr,
  input  logic [axi_rd_pkg::NUM_M-1:0][7:0]                 i_s_arlen,
  input  logic [axi_rd_pkg::NUM_M-1:0][2:0]                 i_s_arsize,
  input  logic [axi_rd_pkg::NUM_M-1:0][1:0]                 i_s_arburst,
  output logic [axi_rd_pkg::NUM_M-1:0]                      o_s_arready,
  output logic [axi_rd_pkg::NUM_M-1:0]                      o_s_rvalid,
  output logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ID_W-1:0] o_s_rid,
  output logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::DATA_W-1:0] o_s_rdata,
  output logic [axi_rd_pkg::NUM_M-1:0][1:0]                 o_s_rresp,
  output logic [axi_rd_pkg::NUM_M-1:0]                      o_s_rlast,
  input  logic [axi_rd_pkg::NUM_M-1:0]                      i_s_rready,

  // memory side
  output logic                                              o_m_arvalid,
  output logic [axi_rd_pkg::M_ID_W-1:0]                     o_m_arid,
  output logic [axi_rd_pkg::ADDR_W-1:0]                     o_m_araddr,
  output logic [7:0]                                        o_m_arlen,
  output logic [2:0]                                        o_m_arsize,
  output logic [1:0]                                        o_m_arburst,
  input  logic                                              i_m_arready,
  input  logic                                              i_m_rvalid,
  input  logic [axi_rd_pkg::M_ID_W-1:0]                     i_m_rid,
  input  logic [axi_rd_pkg::DATA_W-1:0]                     i_m_rdata,
  input  logic [1:0]                                        i_m_rresp,
  input  logic                                              i_m_rlast,
  output logic                                              o_m_rready
);
  import axi_rd_pkg::*;

  logic                    grant_valid;
  logic [GRANT_W-1:0]      grant_idx;
  logic [NUM_M-1:0]        req_mask;

  logic [NUM_M-1:0]        sb_arvalid;
  ar_beat_t [NUM_M-1:0]    sb_ar;
  logic [NUM_M-1:0]        ar_pop;
  ar_beat_t                gnt_ar;

  logic [GRANT_W-1:0]      r_idx;
  r_beat_t                 r_in;
  r_beat_t [NUM_M-1:0]     r_out;
  logic [NUM_M-1:0]        sb_rready;

  // --------------------
  // address path
  // --------------------

  for (genvar i = 0; i < NUM_M; i++) begin : gen_ar_sb
    ar_beat_t ar_in;

    assign ar_in.id    = i_s_arid[i];
    assign ar_in.addr  = i_s_araddr[i];
    assign ar_in.len   = i_s_arlen[i];
    assign ar_in.size  = i_s_arsize[i];
    assign ar_in.burst = i_s_arburst[i];

    // popped only when this manager holds the grant and the memory accepts
    assign ar_pop[i] = grant_valid && (grant_idx == GRANT_W'(i)) && i_m_arready;

    skid_buffer #(
      .payload_t(ar_beat_t),
      .OUT_REG  (1'b0)
    ) u_ar_sb (
      .clk     (clk),
      .i_arst_n(i_arst_n),
      .i_valid (i_s_arvalid[i]),
      .i_data  (ar_in),
      .o_ready (o_s_arready[i]),
      .o_valid (sb_arvalid[i]),
      .o_data  (sb_ar[i]),
      .i_ready (ar_pop[i])
    );
  end

  // the granted buffer stays valid until popped, keep it out of the search
  assign req_mask = grant_valid ? ~(NUM_M'(1) << grant_idx) : '1;

  rr_arbiter #(
    .N(NUM_M)
  ) u_rr_arbiter (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_request    (sb_arvalid & req_mask),
    .i_done       (o_m_arvalid && i_m_arready),
    .o_grant_valid(grant_valid),
    .o_grant_idx  (grant_idx)
  );

  assign gnt_ar = sb_ar[grant_idx];

  assign o_m_arvalid = grant_valid;
  // manager index rides in the upper id bits
  assign o_m_arid    = {grant_idx, gnt_ar.id};
  assign o_m_araddr  = gnt_ar.addr;
  assign o_m_arlen   = gnt_ar.len;
  assign o_m_arsize  = gnt_ar.size;
  assign o_m_arburst = gnt_ar.burst;

  // --------------------
  // read data path
  // --------------------

  assign r_idx     = i_m_rid[M_ID_W-1 -: GRANT_W];
  assign r_in.id   = i_m_rid[ID_W-1:0];
  assign r_in.data = i_m_rdata;
  assign r_in.resp = i_m_rresp;
  assign r_in.last = i_m_rlast;

  // stall the memory while the addressed buffer is full
  assign o_m_rready = i_m_rvalid && sb_rready[r_idx];

  for (genvar i = 0; i < NUM_M; i++) begin : gen_r_sb
    skid_buffer #(
      .payload_t(r_beat_t),
      .OUT_REG  (1'b1)
    ) u_r_sb (
      .clk     (clk),
      .i_arst_n(i_arst_n),
      .i_valid (i_m_rvalid && (r_idx == GRANT_W'(i))),
      .i_data  (r_in),
      .o_ready (sb_rready[i]),
      .o_valid (o_s_rvalid[i]),
      .o_data  (r_out[i]),
      .i_ready (i_s_rready[i])
    );

    assign o_s_rid[i]   = r_out[i].id;
    assign o_s_rdata[i] = r_out[i].data;
    assign o_s_rresp[i] = r_out[i].resp;
    assign o_s_rlast[i] = r_out[i].last;
  end

endmodule

//--- axi_rd_chk.sv
`timescale 1ns/10ps

module axi_rd_chk (
  input logic                                                 clk,
  input logic                                                 i_arst_n,
  input logic                                                 o_m_arvalid,
  input logic [axi_rd_pkg::M_ID_W-1:0]                        o_m_arid,
  input logic [axi_rd_pkg::ADDR_W-1:0]                        o_m_araddr,
  input logic [7:0]                                           o_m_arlen,
  input logic [2:0]                                           o_m_arsize,
  input logic [1:0]                                           o_m_arburst,
  input logic                                                 i_m_arready,
  input logic                                                 i_m_rvalid,
  input logic [axi_rd_pkg::M_ID_W-1:0]                        i_m_rid,
  input logic                                                 o_m_rready,
  input logic [axi_rd_pkg::NUM_M-1:0]                         o_s_rvalid,
  input logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ID_W-1:0]   o_s_rid,
  input logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::DATA_W-1:0] o_s_rdata,
  input logic [axi_rd_pkg::NUM_M-1:0][1:0]                    o_s_rresp,
  input logic [axi_rd_pkg::NUM_M-1:0]                         o_s_rlast,
  input logic [axi_rd_pkg::NUM_M-1:0]                         i_s_rready
);
  import axi_rd_pkg::*;

  // a request toward the memory holds until arready
  assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_m_arvalid && !i_m_arready) |=> (o_m_arvalid &&
      $stable({o_m_arid, o_m_araddr, o_m_arlen, o_m_arsize, o_m_arburst})))
    else $error("memory-side AR request changed before arready");

  for (genvar i = 0; i < NUM_M; i++) begin : gen_r
    assert property (@(posedge clk) disable iff (!i_arst_n)
      (o_s_rvalid[i] && !i_s_rready[i]) |=> (o_s_rvalid[i] &&
        $stable({o_s_rid[i], o_s_rdata[i], o_s_rresp[i], o_s_rlast[i]})))
      else $error("R beat at manager %0d changed before rready", i);

    // an empty R path never holds off the memory
    assert property (@(posedge clk) disable iff (!i_arst_n)
      (i_m_rvalid && (i_m_rid[M_ID_W-1 -: GRANT_W] == GRANT_W'(i)) && !o_s_rvalid[i])
        |-> o_m_rready)
      else $error("memory-side rready low while the R path of manager %0d is empty", i);
  end

endmodule

bind axi_rd_arbiter axi_rd_chk u_chk (
  .clk        (clk),
  .i_arst_n   (i_arst_n),
  .o_m_arvalid(o_m_arvalid),
  .o_m_arid   (o_m_arid),
  .o_m_araddr (o_m_araddr),
  .o_m_arlen  (o_m_arlen),
  .o_m_arsize (o_m_arsize),
  .o_m_arburst(o_m_arburst),
  .i_m_arready(i_m_arready),
  .i_m_rvalid (i_m_rvalid),
  .i_m_rid    (i_m_rid),
  .o_m_rready (o_m_rready),
  .o_s_rvalid (o_s_rvalid),
  .o_s_rid    (o_s_rid),
  .o_s_rdata  (o_s_rdata),
  .o_s_rresp  (o_s_rresp),
  .o_s_rlast  (o_s_rlast),
  .i_s_rready (i_s_rready)
);

//--- axi_rd_mem.sv
`timescale 1ns/10ps

module axi_rd_mem (
  input  logic                          clk,
  input  logic                          i_arst_n,
  input  logic                          i_arvalid,
  input  logic [axi_rd_pkg::M_ID_W-1:0] i_arid,
  input  logic [axi_rd_pkg::ADDR_W-1:0] i_araddr,
  input  logic [7:0]                    i_arlen,
  input  logic [2:0]                    i_arsize,
  input  logic [1:0]                    i_arburst,
  output logic                          o_arready,
  output logic                          o_rvalid,
  output logic [axi_rd_pkg::M_ID_W-1:0] o_rid,
  output logic [axi_rd_pkg::DATA_W-1:0] o_rdata,
  output logic [1:0]                    o_rresp,
  output logic                          o_rlast,
  input  logic                          i_rready
);
  import axi_rd_pkg::*;

  typedef logic [$clog2(MEM_WORDS)-1:0] word_t;

  logic [DATA_W-1:0]            rom [MEM_WORDS];

  logic                         busy;
  logic [7:0]                   beat_cnt;
  logic [7:0]                   len_q;
  logic [M_ID_W-1:0]            id_q;
  word_t                        word_addr;
  logic                         fixed_q;
  logic                         err_q;
  logic                         ar_fire;
  logic                         r_fire;
  logic                         req_err;

  initial begin
    $readmemh("mem_init.hex", rom);
  end

  assign ar_fire = i_arvalid && o_arready;
  assign r_fire  = o_rvalid && i_rready;

  // wrap bursts and narrow reads are not served
  assign req_err = (i_arburst == BURST_WRAP) || (i_arsize != 3'($clog2(DATA_W / 8)));

  // one burst at a time
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      busy     <= 1'b0;
      beat_cnt <= '0;
    end else if (ar_fire) begin
      busy     <= 1'b1;
      beat_cnt <= '0;
    end else if (r_fire) begin
      busy     <= !o_rlast;
      beat_cnt <= beat_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q      <= i_arid;
      len_q     <= i_arlen;
      fixed_q   <= (i_arburst == BURST_FIXED);
      err_q     <= req_err;
      // upper byte address bits drop off so the word index wraps
      word_addr <= i_araddr[$clog2(DATA_W / 8) +: $clog2(MEM_WORDS)];
    end else if (r_fire && !fixed_q) begin
      word_addr <= word_addr + word_t'(1);
    end
  end

  assign o_arready = !busy;
  assign o_rvalid  = busy;
  assign o_rid     = id_q;
  assign o_rdata   = err_q ? '0 : rom[word_addr];
  assign o_rresp   = err_q ? RESP_SLVERR : RESP_OKAY;
  assign o_rlast   = (beat_cnt == len_q);

endmodule

//--- axi_rd_pkg.sv
package axi_rd_pkg;

  // system sizes
  localparam int NUM_M     = 2;
  localparam int GRANT_W   = 1;
  localparam int ADDR_W    = 6;
  localparam int DATA_W    = 16;
  localparam int ID_W      = 4;
  localparam int M_ID_W    = ID_W + GRANT_W;
  localparam int MEM_WORDS = 32;

  // arburst encodings
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  // rresp encodings
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } ar_beat_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_beat_t;

endpackage

//--- axi_rd_subsys.sv
`timescale 1ns/10ps

module axi_rd_subsys (
  input  logic                                              clk,
  input  logic                                              i_arst_n,
  input  logic [axi_rd_pkg::NUM_M-1:0]                      i_s_arvalid,
  input  logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ID_W-1:0] i_s_arid,
  input  logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ADDR_W-1:0] i_s_araddr,
  input  logic [axi_rd_pkg::NUM_M-1:0][7:0]                 i_s_arlen,
  input  logic [axi_rd_pkg::NUM_M-1:0][2:0]                 i_s_arsize,
  input  logic [axi_rd_pkg::NUM_M-1:0][1:0]                 i_s_arburst,
  output logic [axi_rd_pkg::NUM_M-1:0]                      o_s_arready,
  output logic [axi_rd_pkg::NUM_M-1:0]                      o_s_rvalid,
  output logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::ID_W-1:0] o_s_rid,
  output logic [axi_rd_pkg::NUM_M-1:0][axi_rd_pkg::DATA_W-1:0] o_s_rdata,
  output logic [axi_rd_pkg::NUM_M-1:0][1:0]                 o_s_rresp,
  output logic [axi_rd_pkg::NUM_M-1:0]                      o_s_rlast,
  input  logic [axi_rd_pkg::NUM_M-1:0]                      i_s_rready
);
  import axi_rd_pkg::*;

  // arbiter to memory
  logic              m_arvalid;
  logic [M_ID_W-1:0] m_arid;
  logic [ADDR_W-1:0] m_araddr;
  logic [7:0]        m_arlen;
  logic [2:0]        m_arsize;
  logic [1:0]        m_arburst;
  logic              m_arready;
  logic              m_rvalid;
  logic [M_ID_W-1:0] m_rid;
  logic [DATA_W-1:0] m_rdata;
  logic [1:0]        m_rresp;
  logic              m_rlast;
  logic              m_rready;

  axi_rd_arbiter u_arbiter (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_s_arvalid(i_s_arvalid),
    .i_s_arid   (i_s_arid),
    .i_s_araddr (i_s_araddr),
    .i_s_arlen  (i_s_arlen),
    .i_s_arsize (i_s_arsize),
    .i_s_arburst(i_s_arburst),
    .o_s_arready(o_s_arready),
    .o_s_rvalid (o_s_rvalid),
    .o_s_rid    (o_s_rid),
    .o_s_rdata  (o_s_rdata),
    .o_s_rresp  (o_s_rresp),
    .o_s_rlast  (o_s_rlast),
    .i_s_rready (i_s_rready),
    .o_m_arvalid(m_arvalid),
    .o_m_arid   (m_arid),
    .o_m_araddr (m_araddr),
    .o_m_arlen  (m_arlen),
    .o_m_arsize (m_arsize),
    .o_m_arburst(m_arburst),
    .i_m_arready(m_arready),
    .i_m_rvalid (m_rvalid),
    .i_m_rid    (m_rid),
    .i_m_rdata  (m_rdata),
    .i_m_rresp  (m_rresp),
    .i_m_rlast  (m_rlast),
    .o_m_rready (m_rready)
  );

  axi_rd_mem u_mem (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_arvalid(m_arvalid),
    .i_arid   (m_arid),
    .i_araddr (m_araddr),
    .i_arlen  (m_arlen),
    .i_arsize (m_arsize),
    .i_arburst(m_arburst),
    .o_arready(m_arready),
    .o_rvalid (m_rvalid),
    .o_rid    (m_rid),
    .o_rdata  (m_rdata),
    .o_rresp  (m_rresp),
    .o_rlast  (m_rlast),
    .i_rready (m_rready)
  );

endmodule

//--- mem_init.hex
// one 16-bit rom word per line in hex, word address 0 on the first data line
A0FF
A1FE
A2FD
A3FC
A4FB
A5FA
A6F9
A7F8
A8F7
A9F6
AAF5
ABF4
ACF3
ADF2
AEF1
AFF0
B0EF
B1EE
B2ED
B3EC
B4EB
B5EA
B6E9
B7E8
B8E7
B9E6
BAE5
BBE4
BCE3
BDE2
BEE1
BFE0

//--- rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
  parameter int N = 2
) (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic [N-1:0]         i_request,
  input  logic                 i_done,
  output logic                 o_grant_valid,
  output logic [$clog2(N)-1:0] o_grant_idx
);

  typedef logic [$clog2(N)-1:0] idx_t;

  logic found;
  idx_t next_idx;

  // search upward from the last grant, lowest offset wins
  always_comb begin : find_next
    int cand;
    found    = 1'b0;
    next_idx = o_grant_idx;
    for (int k = N; k >= 1; k--) begin
      cand = (int'(o_grant_idx) + k) % N;
      if (i_request[cand]) begin
        found    = 1'b1;
        next_idx = idx_t'(cand);
      end
    end
  end

  // o_grant_idx doubles as the priority pointer once the grant ends
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_grant_valid <= 1'b0;
      // first search then starts at index 0
      o_grant_idx   <= idx_t'(N - 1);
    end else if (o_grant_valid) begin
      if (i_done) begin
        o_grant_valid <= 1'b0;
      end
    end else if (found) begin
      o_grant_valid <= 1'b1;
      o_grant_idx   <= next_idx;
    end
  end

endmodule

//--- skid_buffer.sv
`timescale 1ns/10ps

module skid_buffer #(
  parameter type payload_t = logic,
  parameter bit  OUT_REG   = 1'b0
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,
  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  logic     skid_valid;
  payload_t skid_data;
  // output side holds a beat that is not taken this cycle
  logic     out_stall;

  // ready comes straight from a flop
  assign o_ready = !skid_valid;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      skid_valid <= 1'b0;
    end else if (i_valid && o_ready && out_stall) begin
      skid_valid <= 1'b1;
    end else if (!out_stall) begin
      skid_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (i_valid && o_ready) begin
      skid_data <= i_data;
    end
  end

  if (OUT_REG) begin : gen_out_reg
    logic     out_valid;
    payload_t out_data;

    assign out_stall = out_valid && !i_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
        out_valid <= 1'b0;
      end else if (!out_stall) begin
        out_valid <= i_valid || skid_valid;
      end
    end

    // skid entry drains first so order is kept
    always_ff @(posedge clk) begin
      if (!out_stall) begin
        out_data <= skid_valid ? skid_data : i_data;
      end
    end

    assign o_valid = out_valid;
    assign o_data  = out_data;
  end else begin : gen_pass
    assign o_valid   = i_valid || skid_valid;
    assign o_data    = skid_valid ? skid_data : i_data;
    assign out_stall = o_valid && !i_ready;
  end

endmodule

//--- tb.f
axi_rd_pkg.sv
skid_buffer.sv
rr_arbiter.sv
axi_rd_arbiter.sv
axi_rd_mem.sv
axi_rd_subsys.sv
axi_rd_chk.sv
tb_axi_rd_subsys.sv

//--- tb_axi_rd_subsys.sv
`timescale 1ns/10ps

module tb_axi_rd_subsys;
  import axi_rd_pkg::*;

  localparam int NUM_REQ        = 40;
  // up to 8 beats plus some overhead per burst, times 4 for rready stalls
  localparam int TIMEOUT_CYCLES = 2 * NUM_REQ * (8 + 4) * 4;
  // two bytes per beat
  localparam logic [2:0] SIZE_FULL = 3'd1;

  typedef logic [$clog2(MEM_WORDS)-1:0] word_t;

  logic                            clk;
  logic                            i_arst_n;
  logic [NUM_M-1:0]                s_arvalid;
  logic [NUM_M-1:0][ID_W-1:0]      s_arid;
  logic [NUM_M-1:0][ADDR_W-1:0]    s_araddr;
  logic [NUM_M-1:0][7:0]           s_arlen;
  logic [NUM_M-1:0][2:0]           s_arsize;
  logic [NUM_M-1:0][1:0]           s_arburst;
  logic [NUM_M-1:0]                s_arready;
  logic [NUM_M-1:0]                s_rvalid;
  logic [NUM_M-1:0][ID_W-1:0]      s_rid;
  logic [NUM_M-1:0][DATA_W-1:0]    s_rdata;
  logic [NUM_M-1:0][1:0]           s_rresp;
  logic [NUM_M-1:0]                s_rlast;
  logic [NUM_M-1:0]                s_rready;

  integer            seed;
  int                errors;
  int                cycles;
  int                issued [NUM_M];
  int                beats [NUM_M];
  logic [NUM_M-1:0]  ar_busy;
  logic [DATA_W-1:0] model_mem [MEM_WORDS];
  // expected read beats per manager, in request order
  r_beat_t           exp_q [NUM_M][$];

  axi_rd_subsys dut_i (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_s_arvalid(s_arvalid),
    .i_s_arid   (s_arid),
    .i_s_araddr (s_araddr),
    .i_s_arlen  (s_arlen),
    .i_s_arsize (s_arsize),
    .i_s_arburst(s_arburst),
    .o_s_arready(s_arready),
    .o_s_rvalid (s_rvalid),
    .o_s_rid    (s_rid),
    .o_s_rdata  (s_rdata),
    .o_s_rresp  (s_rresp),
    .o_s_rlast  (s_rlast),
    .i_s_rready (s_rready)
  );

  always #20 clk = ~clk;

  // --------------------
  // stimulus and model
  // --------------------

  task automatic new_request(input int m);
    logic [31:0] rnd;
    rnd          = $random(seed);
    s_arid[m]    = rnd[3:0];
    s_araddr[m]  = {rnd[8:4], 1'b0};
    s_arlen[m]   = {5'd0, rnd[11:9]};
    s_arsize[m]  = SIZE_FULL;
    // mostly incr, some fixed, a few wrap
    if (rnd[15:12] < 4'd11) begin
      s_arburst[m] = BURST_INCR;
    end else if (rnd[15:12] < 4'd14) begin
      s_arburst[m] = BURST_FIXED;
    end else begin
      s_arburst[m] = BURST_WRAP;
    end
    s_arvalid[m] = 1'b1;
    ar_busy[m]   = 1'b1;
  endtask

  task automatic push_expected(input int m);
    r_beat_t beat;
    word_t   word;
    word = s_araddr[m][ADDR_W-1:1];
    for (int k = 0; k <= int'(s_arlen[m]); k++) begin
      beat.id = s_arid[m];
      if (s_arburst[m] == BURST_WRAP) begin
        beat.data = '0;
        beat.resp = RESP_SLVERR;
      end else begin
        beat.data = model_mem[word];
        beat.resp = RESP_OKAY;
      end
      beat.last = (k == int'(s_arlen[m]));
      exp_q[m].push_back(beat);
      // word index wraps around the rom
      if (s_arburst[m] == BURST_INCR) begin
        word = word + word_t'(1);
      end
    end
  endtask

  task automatic drive_manager(input int m);
    logic [31:0] rnd;
    rnd = $random(seed);
    if (!ar_busy[m]) begin
      s_arvalid[m] = 1'b0;
      if (issued[m] < NUM_REQ && rnd[1:0] != 2'b00) begin
        new_request(m);
      end
    end
    rnd         = $random(seed);
    s_rready[m] = (rnd[7:0] < 8'd179);
    // the request transfers at the coming rising edge
    if (s_arvalid[m] && s_arready[m]) begin
      push_expected(m);
      issued[m]++;
      ar_busy[m] = 1'b0;
    end
  endtask

  task automatic check_beat(input int m);
    r_beat_t exp;
    if (s_rvalid[m] && s_rready[m]) begin
      if (exp_q[m].size() == 0) begin
        $display("manager %0d got a read beat with no read outstanding", m);
        errors++;
      end else begin
        exp = exp_q[m].pop_front();
        beats[m]++;
        if (s_rid[m] !== exp.id) begin
          $display("FAILED o_s_rid[%0d]: got %h, expected %h", m, s_rid[m], exp.id);
          errors++;
        end
        if (s_rdata[m] !== exp.data) begin
          $display("FAILED o_s_rdata[%0d]: got %h, expected %h", m, s_rdata[m], exp.data);
          errors++;
        end
        if (s_rresp[m] !== exp.resp) begin
          $display("FAILED o_s_rresp[%0d]: got %h, expected %h", m, s_rresp[m], exp.resp);
          errors++;
        end
        if (s_rlast[m] !== exp.last) begin
          $display("FAILED o_s_rlast[%0d]: got %h, expected %h", m, s_rlast[m], exp.last);
          errors++;
        end
      end
    end
  endtask

  function automatic logic all_done();
    logic done;
    done = 1'b1;
    for (int m = 0; m < NUM_M; m++) begin
      if (issued[m] < NUM_REQ || ar_busy[m] || exp_q[m].size() != 0) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  // --------------------
  // main sequence
  // --------------------

  initial begin : main
    logic finished;
    clk       = 1'b0;
    i_arst_n  = 1'b0;
    s_arvalid = '0;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    s_arsize  = '0;
    s_arburst = '0;
    s_rready  = '0;
    ar_busy   = '0;
    seed      = 32'hbb9c69a7;
    errors    = 0;
    cycles    = 0;
    finished  = 1'b0;
    for (int m = 0; m < NUM_M; m++) begin
      issued[m] = 0;
      beats[m]  = 0;
    end
    $readmemh("mem_init.hex", model_mem);

    repeat (10) @(negedge clk);
    i_arst_n = 1'b1;

    while (!finished && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
      for (int m = 0; m < NUM_M; m++) begin
        drive_manager(m);
        check_beat(m);
      end
      finished = all_done();
    end

    if (!finished) begin
      $display("timeout after %0d cycles with reads still outstanding", cycles);
      errors++;
    end else begin
      // nothing may arrive once every burst has completed
      s_arvalid = '0;
      s_rready  = '1;
      repeat (20) begin
        @(negedge clk);
        if (s_rvalid != '0) begin
          $display("a manager got a read beat after all bursts completed");
          errors++;
        end
      end
    end

    $display("errors %0d, beats at manager 0: %0d, beats at manager 1: %0d",
             errors, beats[0], beats[1]);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
